/* rtl/llc_pkg.sv */
`default_nettype none

package llc_pkg;

    localparam int ADDR_BITS = 16; // line address, no word offset
    localparam int LINE_BITS = 64;
    localparam int ID_BITS   = 4;

    typedef logic [ADDR_BITS-1:0] line_addr_t;
    typedef logic [LINE_BITS-1:0] line_t;
    typedef logic [ID_BITS-1:0]   req_id_t;

    typedef struct packed {
        logic       wr;
        line_addr_t addr;
        line_t      line;
        req_id_t    id;
    } llc_req_t;

    typedef struct packed {
        req_id_t id;
        line_t   line;
    } llc_rsp_t;

    typedef struct packed {
        logic       wr;
        line_addr_t addr;
        line_t      line;
    } llc_mem_req_t;

    typedef struct packed {
        line_t line;
    } llc_mem_rsp_t;

    // full address kept as the tag, so any set count works
    typedef struct packed {
        logic       valid;
        logic       dirty;
        line_addr_t addr;
        line_t      line;
    } way_entry_t;

    typedef enum logic [2:0] {
        DECODE  = 3'b000,
        READ    = 3'b001,
        LOOKUP  = 3'b011,
        PROCESS = 3'b010,
        UPDATE  = 3'b110
    } llc_state_e;

    // index width, at least one bit for a single set or way
    function automatic int idx_bits(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

endpackage

`default_nettype wire

/* rtl/llc_in_buf.sv */
`default_nettype none

module llc_in_buf #(
    parameter type payload_t = logic
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire payload_t data_i,
    input  wire logic     valid_i,
    output logic          ready_o,
    input  wire logic     pop_i,
    output payload_t      data_o,
    output logic          full_o
);

    logic full_q;

    assign ready_o = !full_q; // one entry, so ready only when empty
    assign full_o  = full_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            full_q <= 1'b0;
        end else if (valid_i && ready_o) begin
            full_q <= 1'b1;
        end else if (pop_i) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i && ready_o) begin
            data_o <= data_i;
        end
    end

endmodule

`default_nettype wire

/* rtl/llc_localmem.sv */
`default_nettype none

module llc_localmem import llc_pkg::*; #(
    parameter int  LLC_SETS = 8,
    parameter int  LLC_WAYS = 2,
    localparam int SET_BITS = idx_bits(LLC_SETS),
    localparam int WAY_BITS = idx_bits(LLC_WAYS)
) (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic [SET_BITS-1:0]          set_i,
    input  wire logic                         rd_en_i,
    output way_entry_t [LLC_WAYS-1:0]         rd_ways_o,
    output logic [WAY_BITS-1:0]               rd_evict_way_o,
    input  wire logic                         wr_en_i,
    input  wire way_entry_t [LLC_WAYS-1:0]    wr_ways_i,
    input  wire logic                         evict_adv_i
);

    logic                valid_q [LLC_SETS][LLC_WAYS];
    logic                dirty_q [LLC_SETS][LLC_WAYS];
    line_addr_t          addr_q  [LLC_SETS][LLC_WAYS];
    line_t               line_q  [LLC_SETS][LLC_WAYS];
    logic [WAY_BITS-1:0] evict_q [LLC_SETS]; // round-robin pointer per set

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < LLC_SETS; s++) begin
                evict_q[s] <= '0;
                for (int w = 0; w < LLC_WAYS; w++) begin
                    valid_q[s][w] <= 1'b0;
                    dirty_q[s][w] <= 1'b0;
                end
            end
        end else if (wr_en_i) begin
            for (int w = 0; w < LLC_WAYS; w++) begin
                valid_q[set_i][w] <= wr_ways_i[w].valid;
                dirty_q[set_i][w] <= wr_ways_i[w].dirty;
            end
            if (evict_adv_i) begin
                evict_q[set_i] <= (evict_q[set_i] == WAY_BITS'(LLC_WAYS - 1)) ?
                                  '0 : evict_q[set_i] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            for (int w = 0; w < LLC_WAYS; w++) begin
                addr_q[set_i][w] <= wr_ways_i[w].addr;
                line_q[set_i][w] <= wr_ways_i[w].line;
            end
        end
    end

    // whole set read out in one cycle
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            for (int w = 0; w < LLC_WAYS; w++) begin
                rd_ways_o[w] <= '{valid: valid_q[set_i][w], dirty: dirty_q[set_i][w],
                                  addr: addr_q[set_i][w], line: line_q[set_i][w]};
            end
            rd_evict_way_o <= evict_q[set_i];
        end
    end

endmodule

`default_nettype wire

/* rtl/llc_lookup_way.sv */
`default_nettype none

module llc_lookup_way import llc_pkg::*; #(
    parameter int  LLC_WAYS = 2,
    localparam int WAY_BITS = idx_bits(LLC_WAYS)
) (
    input  wire way_entry_t [LLC_WAYS-1:0] ways_i,
    input  wire line_addr_t                addr_i,
    input  wire logic [WAY_BITS-1:0]       evict_way_i,
    output logic                           hit_o,
    output logic [WAY_BITS-1:0]            hit_way_o,
    output logic [WAY_BITS-1:0]            victim_way_o
);

    logic free_found;

    always_comb begin
        hit_o        = 1'b0;
        hit_way_o    = '0;
        free_found   = 1'b0;
        victim_way_o = evict_way_i; // used only when the set is full
        for (int w = 0; w < LLC_WAYS; w++) begin
            if (!hit_o && ways_i[w].valid && ways_i[w].addr == addr_i) begin
                hit_o     = 1'b1;
                hit_way_o = WAY_BITS'(w);
            end
            // first invalid way wins over round robin
            if (!free_found && !ways_i[w].valid) begin
                free_found   = 1'b1;
                victim_way_o = WAY_BITS'(w);
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/llc_set_buf.sv */
`default_nettype none

module llc_set_buf import llc_pkg::*; #(
    parameter int  LLC_WAYS = 2,
    localparam int WAY_BITS = idx_bits(LLC_WAYS)
) (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      load_i,
    input  wire way_entry_t [LLC_WAYS-1:0] ways_i,
    input  wire logic                      upd_en_i,
    input  wire logic [WAY_BITS-1:0]       upd_way_i,
    input  wire way_entry_t                upd_entry_i,
    output way_entry_t [LLC_WAYS-1:0]      ways_o
);

    logic       valid_q [LLC_WAYS];
    logic       dirty_q [LLC_WAYS];
    line_addr_t addr_q  [LLC_WAYS];
    line_t      line_q  [LLC_WAYS];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int w = 0; w < LLC_WAYS; w++) begin
                valid_q[w] <= 1'b0;
                dirty_q[w] <= 1'b0;
            end
        end else if (load_i) begin
            for (int w = 0; w < LLC_WAYS; w++) begin
                valid_q[w] <= ways_i[w].valid;
                dirty_q[w] <= ways_i[w].dirty;
            end
        end else if (upd_en_i) begin
            valid_q[upd_way_i] <= upd_entry_i.valid;
            dirty_q[upd_way_i] <= upd_entry_i.dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            for (int w = 0; w < LLC_WAYS; w++) begin
                addr_q[w] <= ways_i[w].addr;
                line_q[w] <= ways_i[w].line;
            end
        end else if (upd_en_i) begin
            addr_q[upd_way_i] <= upd_entry_i.addr;
            line_q[upd_way_i] <= upd_entry_i.line;
        end
    end

    always_comb begin
        for (int w = 0; w < LLC_WAYS; w++) begin
            ways_o[w] = '{valid: valid_q[w], dirty: dirty_q[w], addr: addr_q[w], line: line_q[w]};
        end
    end

endmodule

`default_nettype wire

/* rtl/llc_ctrl.sv */
`default_nettype none

module llc_ctrl import llc_pkg::*; #(
    parameter int  LLC_SETS = 8,
    parameter int  LLC_WAYS = 2,
    localparam int SET_BITS = idx_bits(LLC_SETS),
    localparam int WAY_BITS = idx_bits(LLC_WAYS)
) (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire llc_req_t                  req_i,
    input  wire logic                      req_full_i,
    output logic                           req_pop_o,
    input  wire llc_mem_rsp_t              mem_rsp_i,
    input  wire logic                      mem_rsp_full_i,
    output logic                           mem_rsp_pop_o,
    input  wire logic                      flush_valid_i,
    output logic                           flush_ready_o,
    output logic                           flush_done_o,
    output logic [SET_BITS-1:0]            set_o,
    output logic                           rd_en_o,
    output logic                           load_o,
    input  wire way_entry_t [LLC_WAYS-1:0] ways_i,
    input  wire logic                      hit_i,
    input  wire logic [WAY_BITS-1:0]       hit_way_i,
    input  wire logic [WAY_BITS-1:0]       victim_way_i,
    output logic                           upd_en_o,
    output logic [WAY_BITS-1:0]            upd_way_o,
    output way_entry_t                     upd_entry_o,
    output logic                           wr_en_o,
    output logic                           evict_adv_o,
    output llc_rsp_t                       rsp_o,
    output logic                           rsp_valid_o,
    input  wire logic                      rsp_ready_i,
    output llc_mem_req_t                   mem_req_o,
    output logic                           mem_req_valid_o,
    input  wire logic                      mem_req_ready_i
);

    llc_state_e          state_q, state_d;
    logic                flush_q; // current pass belongs to a flush walk
    logic [SET_BITS-1:0] flush_set_q;
    logic [WAY_BITS-1:0] flush_way_q;
    logic                wb_done_q, fetch_done_q, adv_q;
    logic                process_done, need_wb, need_fetch, line_wb;
    logic                last_set, last_way;
    way_entry_t          victim, hit_entry, flush_entry;

    assign victim      = ways_i[victim_way_i];
    assign hit_entry   = ways_i[hit_way_i];
    assign flush_entry = ways_i[flush_way_q];
    assign need_wb     = !hit_i && victim.valid && victim.dirty && !wb_done_q;
    assign need_fetch  = !hit_i && !req_i.wr;
    assign line_wb     = flush_entry.valid && flush_entry.dirty;
    assign last_set    = flush_set_q == SET_BITS'(LLC_SETS - 1);
    assign last_way    = flush_way_q == WAY_BITS'(LLC_WAYS - 1);

    assign set_o         = flush_q ? flush_set_q : req_i.addr[SET_BITS-1:0];
    assign rd_en_o       = state_q == READ;
    assign load_o        = state_q == LOOKUP;
    assign wr_en_o       = state_q == UPDATE;
    assign evict_adv_o   = wr_en_o && adv_q;
    assign req_pop_o     = wr_en_o && !flush_q;
    assign flush_ready_o = state_q == DECODE && !flush_q && flush_valid_i; // flush first
    assign flush_done_o  = wr_en_o && flush_q && last_set;

    assign rsp_o.id   = req_i.id;
    assign rsp_o.line = req_i.wr ? req_i.line : (hit_i ? hit_entry.line : mem_rsp_i.line);

    always_comb begin
        state_d = state_q;
        case (state_q)
            DECODE:  if (flush_q || flush_valid_i || req_full_i) state_d = READ;
            READ:    state_d = LOOKUP;
            LOOKUP:  state_d = PROCESS;
            PROCESS: if (process_done) state_d = UPDATE;
            UPDATE:  state_d = DECODE;
            default: state_d = DECODE;
        endcase
    end

    always_comb begin
        mem_req_valid_o = 1'b0;
        mem_req_o       = '{wr: 1'b1, addr: victim.addr, line: victim.line};
        rsp_valid_o     = 1'b0;
        mem_rsp_pop_o   = 1'b0;
        process_done    = 1'b0;
        upd_en_o        = 1'b0;
        upd_way_o       = hit_i ? hit_way_i : victim_way_i;
        upd_entry_o     = '{valid: 1'b1, dirty: req_i.wr || (hit_i && hit_entry.dirty),
                            addr: req_i.addr, line: rsp_o.line};
        if (state_q == PROCESS && flush_q) begin
            // one way per step, write back if dirty then invalidate
            mem_req_o       = '{wr: 1'b1, addr: flush_entry.addr, line: flush_entry.line};
            mem_req_valid_o = line_wb;
            upd_way_o       = flush_way_q;
            upd_entry_o     = '{valid: 1'b0, dirty: 1'b0,
                                addr: flush_entry.addr, line: flush_entry.line};
            upd_en_o        = !line_wb || mem_req_ready_i;
            process_done    = upd_en_o && last_way;
        end else if (state_q == PROCESS) begin
            if (need_wb) begin
                mem_req_valid_o = 1'b1;
            end else if (need_fetch && !fetch_done_q) begin
                mem_req_o       = '{wr: 1'b0, addr: req_i.addr, line: '0};
                mem_req_valid_o = 1'b1;
            end else if (!need_fetch || mem_rsp_full_i) begin
                // install together with the response so the lookup stays stable
                rsp_valid_o   = 1'b1;
                upd_en_o      = rsp_ready_i;
                mem_rsp_pop_o = rsp_ready_i && need_fetch;
                process_done  = rsp_ready_i;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q      <= DECODE;
            flush_q      <= 1'b0;
            flush_set_q  <= '0;
            flush_way_q  <= '0;
            wb_done_q    <= 1'b0;
            fetch_done_q <= 1'b0;
            adv_q        <= 1'b0;
        end else begin
            state_q <= state_d;
            if (flush_ready_o) begin
                flush_q <= 1'b1;
            end else if (flush_done_o) begin
                flush_q <= 1'b0;
            end
            if (wr_en_o && flush_q) begin
                flush_set_q <= last_set ? '0 : flush_set_q + 1'b1;
            end
            if (upd_en_o && flush_q) begin
                flush_way_q <= last_way ? '0 : flush_way_q + 1'b1;
            end
            if (state_q == PROCESS && !flush_q && mem_req_valid_o && mem_req_ready_i) begin
                if (need_wb) begin
                    wb_done_q <= 1'b1;
                end else begin
                    fetch_done_q <= 1'b1;
                end
            end
            if (process_done && !flush_q) begin
                adv_q <= !hit_i && victim.valid; // replaced a live line
            end
            if (wr_en_o) begin
                wb_done_q    <= 1'b0;
                fetch_done_q <= 1'b0;
                adv_q        <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/llc_top.sv */
`default_nettype none

module llc_top import llc_pkg::*; #(
    parameter int  LLC_SETS = 8,
    parameter int  LLC_WAYS = 2,
    localparam int SET_BITS = idx_bits(LLC_SETS),
    localparam int WAY_BITS = idx_bits(LLC_WAYS)
) (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire llc_req_t     req_i,
    input  wire logic         req_valid_i,
    output logic              req_ready_o,
    input  wire llc_mem_rsp_t mem_rsp_i,
    input  wire logic         mem_rsp_valid_i,
    output logic              mem_rsp_ready_o,
    input  wire logic         flush_valid_i,
    output logic              flush_ready_o,
    output logic              flush_done_o,
    output llc_rsp_t          rsp_o,
    output logic              rsp_valid_o,
    input  wire logic         rsp_ready_i,
    output llc_mem_req_t      mem_req_o,
    output logic              mem_req_valid_o,
    input  wire logic         mem_req_ready_i
);

    llc_req_t                  req_q;
    llc_mem_rsp_t              mem_rsp_q;
    logic                      req_full, req_pop, mem_rsp_full, mem_rsp_pop;
    logic [SET_BITS-1:0]       set;
    logic                      rd_en, load, wr_en, evict_adv, upd_en, hit;
    logic [WAY_BITS-1:0]       evict_way, hit_way, victim_way, upd_way;
    way_entry_t                upd_entry;
    way_entry_t [LLC_WAYS-1:0] rd_ways, buf_ways;

    llc_in_buf #(.payload_t(llc_req_t)) u_req_buf (
        .clk, .rst, .data_i(req_i), .valid_i(req_valid_i), .ready_o(req_ready_o),
        .pop_i(req_pop), .data_o(req_q), .full_o(req_full)
    );

    // memory fill data waits here until the line is installed
    llc_in_buf #(.payload_t(llc_mem_rsp_t)) u_mem_rsp_buf (
        .clk, .rst, .data_i(mem_rsp_i), .valid_i(mem_rsp_valid_i), .ready_o(mem_rsp_ready_o),
        .pop_i(mem_rsp_pop), .data_o(mem_rsp_q), .full_o(mem_rsp_full)
    );

    llc_ctrl #(.LLC_SETS(LLC_SETS), .LLC_WAYS(LLC_WAYS)) u_ctrl (
        .clk, .rst, .req_i(req_q), .req_full_i(req_full), .req_pop_o(req_pop),
        .mem_rsp_i(mem_rsp_q), .mem_rsp_full_i(mem_rsp_full), .mem_rsp_pop_o(mem_rsp_pop),
        .flush_valid_i, .flush_ready_o, .flush_done_o, .set_o(set), .rd_en_o(rd_en),
        .load_o(load), .ways_i(buf_ways), .hit_i(hit), .hit_way_i(hit_way),
        .victim_way_i(victim_way), .upd_en_o(upd_en), .upd_way_o(upd_way),
        .upd_entry_o(upd_entry), .wr_en_o(wr_en), .evict_adv_o(evict_adv), .rsp_o,
        .rsp_valid_o, .rsp_ready_i, .mem_req_o, .mem_req_valid_o, .mem_req_ready_i
    );

    llc_localmem #(.LLC_SETS(LLC_SETS), .LLC_WAYS(LLC_WAYS)) u_localmem (
        .clk, .rst, .set_i(set), .rd_en_i(rd_en), .rd_ways_o(rd_ways),
        .rd_evict_way_o(evict_way), .wr_en_i(wr_en), .wr_ways_i(buf_ways),
        .evict_adv_i(evict_adv)
    );

    llc_lookup_way #(.LLC_WAYS(LLC_WAYS)) u_lookup_way (
        .ways_i(buf_ways), .addr_i(req_q.addr), .evict_way_i(evict_way),
        .hit_o(hit), .hit_way_o(hit_way), .victim_way_o(victim_way)
    );

    llc_set_buf #(.LLC_WAYS(LLC_WAYS)) u_set_buf (
        .clk, .rst, .load_i(load), .ways_i(rd_ways), .upd_en_i(upd_en),
        .upd_way_i(upd_way), .upd_entry_i(upd_entry), .ways_o(buf_ways)
    );

endmodule

`default_nettype wire

/* dv/llc_top_tb.sv */
`default_nettype none

module llc_top_tb import llc_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int LLC_SETS = 8;
    localparam int LLC_WAYS = 2;
    localparam int POOL     = 24; // random traffic addresses, three per set
    localparam int N_RANDOM = 300;

    logic         clk;
    logic         rst;
    llc_req_t     req_i;
    logic         req_valid_i, req_ready_o;
    llc_mem_rsp_t mem_rsp_i;
    logic         mem_rsp_valid_i, mem_rsp_ready_o;
    logic         flush_valid_i, flush_ready_o, flush_done_o;
    llc_rsp_t     rsp_o;
    logic         rsp_valid_o, rsp_ready_i;
    llc_mem_req_t mem_req_o;
    logic         mem_req_valid_o, mem_req_ready_i;

    logic [31:0]  lcg_state = 32'hc270_9f3c;
    llc_req_t     send_q[$];
    llc_rsp_t     exp_rsp_q[$];
    llc_mem_req_t exp_mreq_q[$];
    line_t        fill_q[$];
    line_t        tb_mem  [line_addr_t]; // memory as written on the mem_req channel
    line_t        ref_mem [line_addr_t]; // memory as the reference model expects it
    bit           m_valid [LLC_SETS][LLC_WAYS];
    bit           m_dirty [LLC_SETS][LLC_WAYS];
    line_addr_t   m_addr  [LLC_SETS][LLC_WAYS];
    line_t        m_line  [LLC_SETS][LLC_WAYS];
    int           m_evict [LLC_SETS];
    int           fill_delay, n_issued, n_rsp, n_done, n_checks, n_errors, err_start;
    int           cycles, limit;
    bit           flush_pending, req_fire, mrsp_fire;
    string        test_name = "reset";

    llc_top #(.LLC_SETS(LLC_SETS), .LLC_WAYS(LLC_WAYS)) u_llc_top (
        .clk, .rst, .req_i, .req_valid_i, .req_ready_o, .mem_rsp_i, .mem_rsp_valid_i,
        .mem_rsp_ready_o, .flush_valid_i, .flush_ready_o, .flush_done_o, .rsp_o,
        .rsp_valid_o, .rsp_ready_i, .mem_req_o, .mem_req_valid_o, .mem_req_ready_i
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16]; // low lcg bits repeat too quickly
    endfunction

    function automatic line_t rand_line();
        return {next_rand(), next_rand(), next_rand(), next_rand()};
    endfunction

    function automatic line_t mem_hash(input line_addr_t a);
        line_addr_t h0, h1;
        h0 = a * 16'h9e37 + 16'h7f4a;
        h1 = {a[7:0], a[15:8]} ^ 16'hc3a5;
        return {h0, h1, ~a, a ^ h0};
    endfunction

    function automatic line_t tb_mem_read(input line_addr_t a);
        return tb_mem.exists(a) ? tb_mem[a] : mem_hash(a);
    endfunction

    function automatic line_t ref_mem_read(input line_addr_t a);
        return ref_mem.exists(a) ? ref_mem[a] : mem_hash(a);
    endfunction

    // write-allocate, write-back, first free way else round robin
    task automatic model_req(input llc_req_t r);
        int       s;
        int       w;
        bit       hit;
        llc_rsp_t rsp;
        s   = int'(r.addr) % LLC_SETS;
        hit = 1'b0;
        w   = m_evict[s];
        for (int i = 0; i < LLC_WAYS; i++) begin
            if (!hit && m_valid[s][i] && m_addr[s][i] == r.addr) begin
                hit = 1'b1;
                w   = i;
            end
        end
        if (!hit) begin
            for (int i = LLC_WAYS - 1; i >= 0; i--) begin
                if (!m_valid[s][i]) w = i;
            end
            if (m_valid[s][w] && m_dirty[s][w]) begin
                exp_mreq_q.push_back(llc_mem_req_t'{1'b1, m_addr[s][w], m_line[s][w]});
                ref_mem[m_addr[s][w]] = m_line[s][w];
            end
            if (m_valid[s][w]) m_evict[s] = (m_evict[s] + 1) % LLC_WAYS;
            if (!r.wr) begin
                exp_mreq_q.push_back(llc_mem_req_t'{1'b0, r.addr, line_t'(0)});
                m_line[s][w] = ref_mem_read(r.addr);
            end
            m_valid[s][w] = 1'b1;
            m_dirty[s][w] = 1'b0;
            m_addr[s][w]  = r.addr;
        end
        if (r.wr) begin
            m_line[s][w]  = r.line;
            m_dirty[s][w] = 1'b1;
        end
        rsp.id   = r.id;
        rsp.line = m_line[s][w];
        exp_rsp_q.push_back(rsp);
    endtask

    task automatic model_flush();
        for (int s = 0; s < LLC_SETS; s++) begin
            for (int w = 0; w < LLC_WAYS; w++) begin
                if (m_valid[s][w] && m_dirty[s][w]) begin
                    exp_mreq_q.push_back(llc_mem_req_t'{1'b1, m_addr[s][w], m_line[s][w]});
                    ref_mem[m_addr[s][w]] = m_line[s][w];
                end
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
            end
        end
    endtask

    task automatic check_rsp(input llc_rsp_t exp, input llc_rsp_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERROR %s: rsp expected id %h line %h, actual id %h line %h",
                     test_name, exp.id, exp.line, act.id, act.line);
        end
    endtask

    task automatic check_mem_req(input llc_mem_req_t exp, input llc_mem_req_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERROR %s: mem_req expected wr %b addr %h line %h, actual wr %b addr %h line %h",
                     test_name, exp.wr, exp.addr, exp.line, act.wr, act.addr, act.line);
        end
    endtask

    // transfers seen at the rising edge, before the DUT updates
    task automatic sample_channels();
        req_fire  = req_valid_i && req_ready_o;
        mrsp_fire = mem_rsp_valid_i && mem_rsp_ready_o;
        if (rsp_valid_o && rsp_ready_i) begin
            if (exp_rsp_q.size() == 0) begin
                n_errors++;
                $display("%s: response id %h arrived with no request open", test_name, rsp_o.id);
            end else begin
                check_rsp(exp_rsp_q.pop_front(), rsp_o);
            end
            n_rsp++;
        end
        if (mem_req_valid_o && mem_req_ready_i) begin
            if (mem_req_o.wr) begin
                tb_mem[mem_req_o.addr] = mem_req_o.line;
            end else begin
                fill_q.push_back(tb_mem_read(mem_req_o.addr));
                fill_delay = next_rand() % 8;
            end
            if (exp_mreq_q.size() == 0) begin
                n_errors++;
                $display("%s: memory request to %h was not expected", test_name, mem_req_o.addr);
            end else begin
                check_mem_req(exp_mreq_q.pop_front(), mem_req_o);
            end
        end
        if (flush_valid_i && flush_ready_o) begin
            flush_pending = 1'b0;
            model_flush();
        end
        if (req_fire) model_req(req_i);
        if (flush_done_o) n_done++;
    endtask

    task automatic drive_channels();
        if (req_fire) req_valid_i = 1'b0;
        if (!req_valid_i && send_q.size() > 0 && next_rand() % 4 != 0) begin
            req_i       = send_q.pop_front();
            req_valid_i = 1'b1;
        end
        if (mrsp_fire) mem_rsp_valid_i = 1'b0;
        if (fill_q.size() > 0 && !mem_rsp_valid_i) begin
            if (fill_delay > 0) begin
                fill_delay--;
            end else begin
                mem_rsp_i.line  = fill_q.pop_front();
                mem_rsp_valid_i = 1'b1;
            end
        end
        rsp_ready_i     = next_rand() % 4 != 0;
        mem_req_ready_i = next_rand() % 4 != 0;
        flush_valid_i   = flush_pending;
    endtask

    initial begin
        forever begin
            @(posedge clk);
            sample_channels();
            @(negedge clk);
            drive_channels();
        end
    end

    // budget grows with every issued request and flush
    initial begin
        while (cycles <= limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles in test %s", cycles, test_name);
        $display("Verification failed");
        $finish;
    end

    task automatic issue(input bit wr, input line_addr_t addr, input line_t line);
        llc_req_t r;
        r.wr   = wr;
        r.addr = addr;
        r.line = line;
        r.id   = req_id_t'(next_rand());
        send_q.push_back(r);
        n_issued++;
        limit += 400;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_start = n_errors;
    endtask

    task automatic end_test();
        wait (n_rsp == n_issued);
        if (exp_mreq_q.size() != 0) begin
            n_errors++;
            $display("%s: %0d expected memory requests never appeared", test_name,
                     exp_mreq_q.size());
            exp_mreq_q.delete();
        end
        $display("test %-10s %s, %0d errors", test_name,
                 (n_errors == err_start) ? "ok" : "FAILED", n_errors - err_start);
    endtask

    initial begin
        rst             = 1'b0;
        req_i           = '0;
        req_valid_i     = 1'b0;
        mem_rsp_i       = '0;
        mem_rsp_valid_i = 1'b0;
        flush_valid_i   = 1'b0;
        rsp_ready_i     = 1'b0;
        mem_req_ready_i = 1'b0;
        limit           = 200;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        start_test("read_miss");
        issue(1'b0, 16'h0011, '0);
        end_test();

        start_test("write_read");
        issue(1'b1, 16'h0022, 64'h0123_4567_89ab_cdef);
        issue(1'b0, 16'h0022, '0);
        end_test();

        start_test("evict");
        issue(1'b1, 16'h0045, 64'h0045_0045_a5a5_0001);
        issue(1'b1, 16'h004d, 64'h004d_004d_5a5a_0002);
        issue(1'b0, 16'h0055, '0); // set 5 full, dirty victim goes out first
        issue(1'b0, 16'h0045, '0);
        issue(1'b0, 16'h004d, '0);
        end_test();

        start_test("random");
        for (int i = 0; i < N_RANDOM; i++) begin
            issue((next_rand() % 2) == 1, line_addr_t'(16'h0100 + next_rand() % POOL),
                  rand_line());
        end
        end_test();

        start_test("flush");
        flush_pending = 1'b1;
        limit += 400 * LLC_SETS;
        wait (n_done > 0);
        for (int a = 0; a < POOL; a++) begin
            issue(1'b0, line_addr_t'(16'h0100 + a), '0);
        end
        issue(1'b0, 16'h0022, '0);
        issue(1'b0, 16'h0045, '0);
        wait (n_rsp == n_issued);
        if (n_done != 1) begin
            n_errors++;
            $display("flush: flush_done_o pulsed %0d times instead of once", n_done);
        end
        end_test();

        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* llc_top.f */
rtl/llc_pkg.sv
rtl/llc_in_buf.sv
rtl/llc_localmem.sv
rtl/llc_lookup_way.sv
rtl/llc_set_buf.sv
rtl/llc_ctrl.sv
rtl/llc_top.sv
dv/llc_top_tb.sv

/* Bender.yml */
package:
  name: llc_top

sources:
  - rtl/llc_pkg.sv
  - rtl/llc_in_buf.sv
  - rtl/llc_localmem.sv
  - rtl/llc_lookup_way.sv
  - rtl/llc_set_buf.sv
  - rtl/llc_ctrl.sv
  - rtl/llc_top.sv
  - target: simulation
    files:
      - dv/llc_top_tb.sv
